/* filelist.f */
src/plps_pkg.sv
src/lb_regs.sv
src/cmd_decode.sv
src/pulse_execute.sv
src/acq_result.sv
src/dsp_top.sv
dv/dsp_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run dsp_tb with Verilator, nonzero exit unless the run passes
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f filelist.f --top-module dsp_tb -o dsp_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/dsp_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
if echo "$out" | grep -qx "Test OK"; then
	exit 0
fi
exit 1

/* dv/dsp_cases.txt */
// Hex, one case per line: id kind w0 w1 w2 adc e0 e1
// kind 1 pulse: w0..w2 commands, e0 DAC runs, e1 min gap; kind 2 acq: w0 cmd, w1 count, e0 sum, e1 settled count
// kind 3 overflow: w0 long pulse, w1 filler, w2 filler count, e0 overflow bit, e1 DAC runs
1 1 52340005 00000000 4AAA0000 00000000 1 0
2 1 00000000 40550000 80000000 00000000 0 0
3 1 41000004 80000014 7FFF0007 00000000 2 14
4 1 4123F006 80000003 43210002 00000000 2 3
5 2 C000000A 00000001 00000000 00000F9C 00FFFC18 1
6 2 C0000010 00000001 00000000 0000007F 000007F0 1
7 3 420000C8 40330003 00000006 00000000 1 5
8 2 C0000008 00000006 00000000 00000005 00000028 4

/* dv/dsp_tb.sv */
// Reads dv/dsp_cases.txt from the project root; DUT built with cmd_depth 4 and res_depth 4
`timescale 1ns/100ps
`default_nettype none

module dsp_tb;
	import plps_pkg::*;

	localparam int wait_limit = 4000;  // Bound on every polling loop
	localparam int quiet_cycles = 40;  // Window for stray activity

	logic cfgclk;
	logic rst_n;
	lb_req_t req;
	logic [lb_data_w-1:0] rdata;
	logic rvalid;
	logic adc_valid;
	logic signed [adc_w-1:0] adc_data;
	logic dac_valid;
	logic [dac_w-1:0] dac_data;

	logic [31:0] cases_mem [128];    // 8 words per case
	logic [31:0] cw [8];             // Current case row
	logic [31:0] seed;
	logic [31:0] exp_len [8];
	logic [dac_w-1:0] exp_val [8];
	logic [7:0] exp_seq;             // Next sequence number due
	logic [31:0] run_len [64];       // DAC runs seen so far
	logic [dac_w-1:0] run_val [64];
	logic [31:0] run_gap [64];       // Low cycles before each run
	logic [31:0] run_cnt;
	logic [31:0] cur_len;
	logic [dac_w-1:0] cur_val;
	logic [31:0] gap_len;
	int errors;
	int checks;
	int cases_run;
	int cases_failed;

	dsp_top #(.cmd_depth(4), .res_depth(4)) dut (
		.cfgclk, .rst_n, .req, .rdata, .rvalid,
		.adc_valid, .adc_data, .dac_valid, .dac_data
	);

	initial begin
		cfgclk = 1'b0;
		forever #5 cfgclk = ~cfgclk; // 10 ns period
	end

	// A run ends on dac_valid low or a new value
	always @(posedge cfgclk) begin
		if (!rst_n) begin
			run_cnt = 0;
			cur_len = 0;
			gap_len = 0;
		end else if (dac_valid && (cur_len == 0 || dac_data == cur_val)) begin
			if (cur_len == 0)
				run_gap[6'(run_cnt)] = gap_len; // First cycle of a run
			cur_val = dac_data;
			cur_len++;
		end else begin
			if (cur_len != 0) begin
				run_len[6'(run_cnt)] = cur_len;
				run_val[6'(run_cnt)] = cur_val;
				run_cnt++;
				gap_len = 0;
			end
			if (dac_valid) begin
				run_gap[6'(run_cnt)] = 0; // Back to back, new value
				cur_val = dac_data;
				cur_len = 1;
			end else begin
				cur_len = 0;
				gap_len++;
			end
		end
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic idle(input int n); // Lands 1 ns after an edge
		repeat (n) begin
			@(posedge cfgclk);
			#1;
		end
	endtask

	task automatic compare_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		assert (got === exp) else begin
			$display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			$display("Error at %0t: %s", $time, what);
			errors++;
		end
	endtask

	task automatic bus_gap();
		logic [31:0] r;
		r = lcg_next();
		idle(32'(r[18:16])); // 0 to 7 idle cycles
	endtask

	task automatic bus_write(input logic [lb_addr_w-1:0] addr, input logic [31:0] data);
		req.wr = 1'b1;
		req.addr = addr;
		req.wdata = data;
		idle(1);
		req = '0;
		bus_gap();
	endtask

	task automatic bus_read(input logic [lb_addr_w-1:0] addr, output logic [31:0] data);
		int n;
		req.rd = 1'b1;
		req.addr = addr;
		idle(1);
		req = '0;
		n = 0;
		while (!rvalid && n < 4) begin
			idle(1);
			n++;
		end
		expect_true(rvalid && n == 0, "read data did not follow the read by one cycle");
		data = rdata;
		bus_gap();
	endtask

	task automatic add_pulse(input logic [31:0] word, inout int n);
		if (word[31:30] == op_pulse && word[11:0] != 12'd0) begin // Len 0 plays nothing
			exp_len[n[2:0]] = 32'(word[11:0]);
			exp_val[n[2:0]] = word[29:16];
			n++;
		end
	endtask

	task automatic wait_runs(input logic [31:0] target);
		int n;
		n = 0;
		while (run_cnt < target && n < wait_limit) begin
			idle(1);
			n++;
		end
		expect_true(n < wait_limit, "timed out waiting for the DAC pulses");
		idle(quiet_cycles); // No extra pulses allowed
		compare_val("dac run count", target, run_cnt);
		expect_true(cur_len == 0, "DAC still active after the expected pulses");
	endtask

	task automatic check_runs(input logic [31:0] base, input int count);
		logic [5:0] k;
		for (int i = 0; i < count; i++) begin
			k = 6'(base + 32'(i));
			compare_val("dac run length", exp_len[i[2:0]], run_len[k]);
			compare_val("dac_data", 32'(exp_val[i[2:0]]), 32'(run_val[k]));
		end
	endtask

	task automatic wait_results(input logic [31:0] target, output logic [31:0] status);
		int n;
		n = 0;
		bus_read(reg_status, status);
		while (status[7:0] < target[7:0] && n < wait_limit) begin
			bus_read(reg_status, status);
			n++;
		end
		expect_true(n < wait_limit, "timed out waiting for result words");
	endtask

	task automatic pulse_case();
		logic [31:0] base;
		logic [31:0] status;
		int n;
		base = run_cnt;
		n = 0;
		for (int i = 2; i < 5; i++) begin
			bus_write(reg_cmd, cw[i[2:0]]);
			add_pulse(cw[i[2:0]], n);
		end
		wait_runs(base + cw[6]);
		check_runs(base, n);
		if (cw[7] != 0 && n > 1) begin // Wait between two pulses
			checks++;
			assert (run_gap[6'(base + 32'd1)] >= cw[7]) else begin
				$display("MISMATCH at %0t: dac gap expected >= %0d, got %0d",
					$time, cw[7], run_gap[6'(base + 32'd1)]);
				errors++;
			end
		end
		bus_read(reg_status, status);
		compare_val("status", 32'd0, status);
	endtask

	task automatic acq_case();
		logic [31:0] rd;
		for (int i = 0; i < cw[3]; i++)
			bus_write(reg_cmd, cw[2]);
		wait_results(cw[7], rd);
		idle(quiet_cycles);
		bus_read(reg_status, rd);
		compare_val("res_count", cw[7], rd); // Full queue holds the rest back
		for (int i = 0; i < cw[3]; i++) begin
			wait_results(1, rd);
			bus_read(reg_result, rd);
			compare_val("result seq", 32'(exp_seq), 32'(rd[31:24]));
			compare_val("result sum", cw[6], 32'(rd[23:0]));
			exp_seq = exp_seq + 8'd1;
		end
		bus_read(reg_result, rd);
		compare_val("empty result read", 32'd0, rd);
	endtask

	task automatic overflow_case();
		logic [31:0] base;
		logic [31:0] status;
		int n;
		base = run_cnt;
		n = 0;
		bus_write(reg_cmd, cw[2]); // Long pulse keeps the sequencer busy
		add_pulse(cw[2], n);
		for (int i = 0; i < cw[4]; i++)
			bus_write(reg_cmd, cw[3]);
		for (int i = 1; i < cw[7]; i++)
			add_pulse(cw[3], n); // Accepted fillers only
		bus_read(reg_status, status);
		compare_val("status overflow", cw[6] << 8, status);
		bus_read(reg_status, status);
		compare_val("status after clear", 32'd0, status);
		wait_runs(base + cw[7]);
		check_runs(base, n);
	endtask

	initial begin
		logic [31:0] idx;
		int err_before;
		rst_n = 1'b0;
		req = '0;
		adc_valid = 1'b0;
		adc_data = '0;
		seed = 32'ha9a35934;
		exp_seq = 8'd0;
		errors = 0;
		checks = 0;
		cases_run = 0;
		cases_failed = 0;
		for (int i = 0; i < 128; i++)
			cases_mem[i[6:0]] = '0; // Zero id ends the table
		$readmemh("dv/dsp_cases.txt", cases_mem);
		repeat (5) @(posedge cfgclk);
		#1;
		rst_n = 1'b1;
		adc_valid = 1'b1; // ADC always delivering
		idle(2);
		idx = 0;
		while (idx < 16 && cases_mem[7'(idx * 8)] != 0) begin
			for (int k = 0; k < 8; k++)
				cw[k[2:0]] = cases_mem[7'(idx * 8 + 32'(k))];
			err_before = errors;
			adc_data = cw[5][adc_w-1:0];
			case (cw[1])
				32'd1: pulse_case();
				32'd2: acq_case();
				32'd3: overflow_case();
				default: expect_true(1'b0, "unknown case kind in the case table");
			endcase
			cases_run++;
			if (errors != err_before)
				cases_failed++;
			$display("case %0d kind %0d: %s", cw[0], cw[1], (errors == err_before) ? "pass" : "FAIL");
			idx++;
		end
		$display("cases %0d, failed %0d, checks %0d, errors %0d",
			cases_run, cases_failed, checks, errors);
		if (errors == 0 && cases_run > 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* src/dsp_top.sv */
// Command block top on cfgclk; depths must be powers of two from 2 to 16
`timescale 1ns/100ps
`default_nettype none

module dsp_top #(
	parameter int cmd_depth = 4, // Decode queue slots
	parameter int res_depth = 4  // Result queue slots
) (
	input wire cfgclk,
	input wire rst_n,
	input wire plps_pkg::lb_req_t req,
	output logic [plps_pkg::lb_data_w-1:0] rdata,
	output logic rvalid,
	input wire adc_valid,
	input wire logic signed [plps_pkg::adc_w-1:0] adc_data,
	output logic dac_valid,
	output logic [plps_pkg::dac_w-1:0] dac_data
);
	import plps_pkg::*;

	logic cmd_push;
	logic [lb_data_w-1:0] cmd_word;
	logic cmd_credit;
	logic cmd_valid;
	cmd_t cmd;
	logic cmd_take;
	logic res_push;
	result_t res;
	logic res_pop;
	result_t res_head;
	logic [7:0] res_count;
	logic res_credit;

	lb_regs #(.cmd_depth(cmd_depth)) u_regs (
		.cfgclk, .rst_n, .req, .cmd_credit, .res_head, .res_count,
		.rdata, .rvalid, .cmd_push, .cmd_word, .res_pop
	);

	cmd_decode #(.cmd_depth(cmd_depth)) u_decode (
		.cfgclk, .rst_n, .cmd_push, .cmd_word, .cmd_take,
		.cmd_valid, .cmd, .cmd_credit
	);

	pulse_execute #(.res_depth(res_depth)) u_exec (
		.cfgclk, .rst_n, .cmd_valid, .cmd, .adc_valid, .adc_data, .res_credit,
		.cmd_take, .dac_valid, .dac_data, .res_push, .res
	);

	acq_result #(.res_depth(res_depth)) u_result (
		.cfgclk, .rst_n, .res_push, .res, .res_pop,
		.res_head, .res_count, .res_credit
	);

endmodule

`default_nettype wire

/* src/acq_result.sv */
// Result FIFO; res_depth must be a power of two up to 16, pushes arrive under credit
`timescale 1ns/100ps
`default_nettype none

module acq_result #(
	parameter int res_depth = 4
) (
	input wire cfgclk,
	input wire rst_n,
	input wire res_push,
	input wire plps_pkg::result_t res,
	input wire res_pop,
	output plps_pkg::result_t res_head,
	output logic [7:0] res_count,
	output logic res_credit
);
	import plps_pkg::*;

	localparam int ptr_w = $clog2(res_depth);

	result_t mem [res_depth]; // Result words, no reset
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w:0] count;

	assign res_head = mem[rd_ptr]; // Oldest result
	assign res_count = 8'(count);

	always_ff @(posedge cfgclk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			res_credit <= 1'b0;
		end else begin
			if (res_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (res_pop)
				rd_ptr <= rd_ptr + 1'b1; // Pop only when nonempty
			count <= count + (ptr_w + 1)'(res_push) - (ptr_w + 1)'(res_pop);
			res_credit <= res_pop; // One credit per pop
		end
	end

	always_ff @(posedge cfgclk) begin
		if (res_push)
			mem[wr_ptr] <= res;
	end

endmodule

`default_nettype wire

/* src/pulse_execute.sv */
// Command sequencer; one idle cycle between commands, acquisitions start only with a result credit
`timescale 1ns/100ps
`default_nettype none

module pulse_execute #(
	parameter int res_depth = 4
) (
	input wire cfgclk,
	input wire rst_n,
	input wire cmd_valid,
	input wire plps_pkg::cmd_t cmd,
	input wire adc_valid,
	input wire logic signed [plps_pkg::adc_w-1:0] adc_data,
	input wire res_credit,
	output logic cmd_take,
	output logic dac_valid,
	output logic [plps_pkg::dac_w-1:0] dac_data,
	output logic res_push,
	output plps_pkg::result_t res
);
	import plps_pkg::*;

	localparam int cred_w = $clog2(res_depth + 1);

	exec_state_e state;
	logic [len_w-1:0] remain;       // Cycles or samples left
	logic [dac_w-1:0] amp_r;        // Latched pulse amplitude
	logic [cred_w-1:0] credits;     // Free result queue slots
	logic signed [sum_w-1:0] acc;
	logic signed [sum_w-1:0] acc_next;
	logic [seq_w-1:0] seq;
	logic zero_len;
	logic acq_start;
	logic last;
	logic sample;

	assign zero_len = (cmd.len == '0);
	assign last = (remain == len_w'(1));
	assign sample = (state == st_acq) && adc_valid;
	assign acc_next = acc + {{(sum_w - adc_w){adc_data[adc_w-1]}}, adc_data}; // Sign extend

	// Acq waits in idle for a credit, all else goes straight through
	always_comb begin
		cmd_take = 1'b0;
		if (state == st_idle && cmd_valid)
			cmd_take = (cmd.opcode != op_acq) || zero_len || (credits != '0);
	end

	assign acq_start = cmd_take && (cmd.opcode == op_acq) && !zero_len; // Spends a credit
	assign dac_valid = (state == st_pulse);
	assign dac_data = dac_valid ? amp_r : '0;

	always_ff @(posedge cfgclk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			remain <= '0;
			credits <= cred_w'(res_depth);
			seq <= '0;
			res_push <= 1'b0;
		end else begin
			res_push <= 1'b0;
			credits <= credits + cred_w'(res_credit) - cred_w'(acq_start);
			case (state)
				st_idle: begin
					if (cmd_take && !zero_len) begin // Nop and len 0 retire here
						remain <= cmd.len;
						case (cmd.opcode)
							op_pulse: state <= st_pulse;
							op_wait: state <= st_wait;
							op_acq: state <= st_acq;
							default: state <= st_idle;
						endcase
					end
				end
				st_pulse, st_wait: begin
					remain <= remain - 1'b1;
					if (last)
						state <= st_idle;
				end
				st_acq: begin
					if (adc_valid) begin // Count only valid samples
						remain <= remain - 1'b1;
						if (last) begin
							state <= st_idle;
							res_push <= 1'b1;
							seq <= seq + 1'b1; // Wraps at 256
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge cfgclk) begin
		if (cmd_take) begin
			amp_r <= cmd.amp;
			acc <= '0;
		end
		if (sample)
			acc <= acc_next;
		if (sample && last) begin
			res.seq <= seq;
			res.sum <= acc_next; // Includes final sample
		end
	end

endmodule

`default_nettype wire

/* src/cmd_decode.sv */
// Decode queue of raw command words; cmd_depth must be a power of two, pushes arrive under credit
`timescale 1ns/100ps
`default_nettype none

module cmd_decode #(
	parameter int cmd_depth = 4
) (
	input wire cfgclk,
	input wire rst_n,
	input wire cmd_push,
	input wire logic [plps_pkg::lb_data_w-1:0] cmd_word,
	input wire cmd_take,
	output logic cmd_valid,
	output plps_pkg::cmd_t cmd,
	output logic cmd_credit
);
	import plps_pkg::*;

	localparam int ptr_w = $clog2(cmd_depth);

	logic [lb_data_w-1:0] mem [cmd_depth]; // Raw words, no reset
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w:0] count;
	logic [lb_data_w-1:0] head;
	logic pop;

	assign head = mem[rd_ptr];
	assign cmd_valid = (count != '0);
	assign pop = cmd_take && cmd_valid;

	// Split head word, reserved bits 15:12 dropped
	always_comb begin
		cmd.opcode = opcode_e'(head[lb_data_w-1 -: 2]);
		cmd.amp = head[lb_data_w-3 -: dac_w];
		cmd.len = head[len_w-1:0];
	end

	always_ff @(posedge cfgclk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			cmd_credit <= 1'b0;
		end else begin
			if (cmd_push)
				wr_ptr <= wr_ptr + 1'b1; // Wraps at depth
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (ptr_w + 1)'(cmd_push) - (ptr_w + 1)'(pop);
			cmd_credit <= pop; // Slot freed, give credit back
		end
	end

	always_ff @(posedge cfgclk) begin
		if (cmd_push)
			mem[wr_ptr] <= cmd_word;
	end

endmodule

`default_nettype wire

/* src/lb_regs.sv */
// Local-bus registers; read data valid one cycle after rd, writes to unmapped addresses ignored
`timescale 1ns/100ps
`default_nettype none

module lb_regs #(
	parameter int cmd_depth = 4
) (
	input wire cfgclk,
	input wire rst_n,
	input wire plps_pkg::lb_req_t req,
	input wire cmd_credit,
	input wire plps_pkg::result_t res_head,
	input wire logic [7:0] res_count,
	output logic [plps_pkg::lb_data_w-1:0] rdata,
	output logic rvalid,
	output logic cmd_push,
	output logic [plps_pkg::lb_data_w-1:0] cmd_word,
	output logic res_pop
);
	import plps_pkg::*;

	localparam int cred_w = $clog2(cmd_depth + 1);

	logic [cred_w-1:0] credits; // Free slots in decode queue
	logic overflow;             // Sticky, set on dropped command
	logic wr_cmd;
	logic cmd_ok;
	logic rd_status;

	assign wr_cmd = req.wr && (req.addr == reg_cmd);
	assign cmd_ok = wr_cmd && (credits != '0); // Only send with a credit
	assign rd_status = req.rd && (req.addr == reg_status);
	assign res_pop = req.rd && (req.addr == reg_result) && (res_count != 8'd0);

	always_ff @(posedge cfgclk or negedge rst_n) begin
		if (!rst_n) begin
			credits <= cred_w'(cmd_depth); // Queue empty at start
			overflow <= 1'b0;
			cmd_push <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			credits <= credits + cred_w'(cmd_credit) - cred_w'(cmd_ok);
			cmd_push <= cmd_ok;
			rvalid <= req.rd;
			if (wr_cmd && !cmd_ok)
				overflow <= 1'b1; // Drop wins over clear
			else if (rd_status)
				overflow <= 1'b0;
		end
	end

	// Payload, qualified by cmd_push and rvalid
	always_ff @(posedge cfgclk) begin
		if (cmd_ok)
			cmd_word <= req.wdata;
		if (req.rd) begin
			case (req.addr)
				reg_result: rdata <= res_pop ? res_head : '0; // Empty queue reads 0
				reg_status: rdata <= {{(lb_data_w - 9){1'b0}}, overflow, res_count};
				default: rdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/plps_pkg.sv */
// Shared widths, enums and structs; command word is op[31:30] amp[29:16] rsvd[15:12] len[11:0]
`default_nettype none

package plps_pkg;

	localparam int lb_data_w = 32; // Bus data and command word
	localparam int lb_addr_w = 4;  // Bus address
	localparam int dac_w = 14;     // DAC sample and pulse amplitude
	localparam int adc_w = 12;     // Signed ADC sample
	localparam int len_w = 12;     // Length field in cycles
	localparam int seq_w = 8;      // Acquisition sequence number
	localparam int sum_w = 24;     // Signed acquisition sum

	localparam logic [lb_addr_w-1:0] reg_cmd = 4'd0;    // Write only, command push
	localparam logic [lb_addr_w-1:0] reg_result = 4'd1; // Read pops one result
	localparam logic [lb_addr_w-1:0] reg_status = 4'd2; // Count and overflow flag

	typedef enum logic [1:0] {
		op_nop = 2'd0,
		op_pulse = 2'd1,
		op_wait = 2'd2,
		op_acq = 2'd3
	} opcode_e;

	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_pulse = 2'd1,
		st_wait = 2'd2,
		st_acq = 2'd3
	} exec_state_e;

	typedef struct packed {
		logic wr;                    // Write strobe
		logic rd;                    // Read strobe
		logic [lb_addr_w-1:0] addr;
		logic [lb_data_w-1:0] wdata;
	} lb_req_t; // 38 bits

	typedef struct packed {
		opcode_e opcode;
		logic [dac_w-1:0] amp;
		logic [len_w-1:0] len;
	} cmd_t; // 28 bits

	typedef struct packed {
		logic [seq_w-1:0] seq;
		logic signed [sum_w-1:0] sum;
	} result_t; // 32 bits, read back as is

endpackage

`default_nettype wire
